//--- rtl/xalu_cfg.svh
`ifndef XALU_CFG_SVH
`define XALU_CFG_SVH

// Operand and result width
`define XALU_DATA_W 32

// Integer multiplier takes this many low bits of each operand
`define XALU_MUL_W 16

// Marker word for the undefined function code
`define XALU_UNDEF_RESULT 32'hDEAD_DEAD

`endif

//--- rtl/xalu_op_pkg.sv
package xalu_op_pkg;

	////////////////////////////////////////
	// ALU function codes
	////////////////////////////////////////

	// Width of func
	localparam int XALU_FUNC_W = 3;

	// Integer multiplies first, then float ops, then conversions
	typedef enum logic [XALU_FUNC_W-1:0] {
		MUL        = 3'd0,
		UMUL       = 3'd1,
		ADDF       = 3'd2,
		SUBF       = 3'd3,
		MULF       = 3'd4,
		ITF        = 3'd5,
		FTI        = 3'd6,
		// Reserved, result is the marker word
		FUNC_UNDEF = 3'd7
	} xalu_func_e;

endpackage

//--- rtl/fp_format_pkg.sv
package fp_format_pkg;

	// Single precision field sizes
	localparam int FP_EXP_W = 8;
	localparam int FP_MAN_W = 23;
	localparam int FP_BIAS  = 127;

	// All-ones exponent, read as infinity
	localparam logic [FP_EXP_W-1:0] FP_EXP_MAX = '1;

	// Saturation magnitude, sign bit excluded
	localparam logic [FP_EXP_W+FP_MAN_W-1:0] FP_MAX_MAG = 31'h7F7F_FFFF;

	typedef struct packed {
		logic                sign;
		logic [FP_EXP_W-1:0] exp;
		logic [FP_MAN_W-1:0] man;
	} fp_word_t;

	// Leading zero count of a 32-bit word, 32 when all zero
	function automatic logic [5:0] fp_lead_zeros(input logic [31:0] v);
		logic [5:0] count;
		logic       found;
		count = 6'd32;
		found = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (!found && v[i]) begin
				count = 6'(31 - i);
				found = 1'b1;
			end
		end
		return count;
	endfunction

endpackage

//--- rtl/fp_adder.sv
`timescale 1ns/10ps
`include "xalu_cfg.svh"

module fp_adder (
	input  logic [`XALU_DATA_W-1:0] a,
	input  logic [`XALU_DATA_W-1:0] b,
	output logic [`XALU_DATA_W-1:0] sum
);
	import fp_format_pkg::*;

	// Exponent limit in the signed working width
	localparam logic signed [FP_EXP_W+1:0] EXP_SAT = {2'b00, FP_EXP_MAX};

	fp_word_t fa;
	fp_word_t fb;
	fp_word_t big;
	fp_word_t small_op;
	fp_word_t res;
	logic a_zero;
	logic b_zero;
	logic a_inf;
	logic b_inf;
	logic [FP_EXP_W-1:0] exp_diff;
	logic [FP_MAN_W:0] big_m;
	logic [FP_MAN_W:0] small_m;
	logic [FP_MAN_W:0] small_al;
	logic [FP_MAN_W+1:0] man_sum;
	logic [5:0] lz;
	logic [FP_MAN_W:0] norm_m;
	logic signed [FP_EXP_W+1:0] res_exp;

	assign fa = a;
	assign fb = b;

	// Exponent 0 is zero, all ones is infinity
	assign a_zero = (fa.exp == '0);
	assign b_zero = (fb.exp == '0);
	assign a_inf = (fa.exp == FP_EXP_MAX);
	assign b_inf = (fb.exp == FP_EXP_MAX);

	////////////////////////////////////////
	// Order and align
	////////////////////////////////////////

	// Larger magnitude goes first, ties keep a
	always_comb begin
		if ({fb.exp, fb.man} > {fa.exp, fa.man}) begin
			big = fb;
			small_op = fa;
		end else begin
			big = fa;
			small_op = fb;
		end
	end

	assign exp_diff = big.exp - small_op.exp;
	assign big_m = {1'b1, big.man};
	assign small_m = {1'b1, small_op.man};
	// Shifted-out bits are dropped, nothing kept for rounding
	assign small_al = (exp_diff > FP_MAN_W) ? '0 : (small_m >> exp_diff);

	// Like signs add, unlike signs subtract the smaller
	assign man_sum = (big.sign == small_op.sign) ? ({1'b0, big_m} + {1'b0, small_al})
	                                             : ({1'b0, big_m} - {1'b0, small_al});

	////////////////////////////////////////
	// Normalize
	////////////////////////////////////////

	// Padding with zeros keeps the count on the 24 low bits
	assign lz = fp_lead_zeros({man_sum[FP_MAN_W:0], 8'h00});

	always_comb begin
		if (man_sum[FP_MAN_W+1]) begin
			// Carry out, one step right
			norm_m = man_sum[FP_MAN_W+1:1];
			res_exp = $signed({2'b00, big.exp}) + 10'sd1;
		end else begin
			norm_m = man_sum[FP_MAN_W:0] << lz;
			res_exp = $signed({2'b00, big.exp}) - $signed({4'b0000, lz});
		end
	end

	// Special operands first, then range checks on the normal path
	always_comb begin
		if (a_inf || b_inf) begin
			res = {(a_inf ? fa.sign : fb.sign), FP_MAX_MAG};
		end else if (a_zero && b_zero) begin
			// Negative only when both zeros are negative
			res = {(fa.sign & fb.sign), {(FP_EXP_W + FP_MAN_W){1'b0}}};
		end else if (a_zero) begin
			res = fb;
		end else if (b_zero) begin
			res = fa;
		end else if (man_sum == '0) begin
			// Exact cancellation
			res = '0;
		end else if (res_exp >= EXP_SAT) begin
			res = {big.sign, FP_MAX_MAG};
		end else if (res_exp <= 10'sd0) begin
			// Underflow keeps the sign
			res = {big.sign, {(FP_EXP_W + FP_MAN_W){1'b0}}};
		end else begin
			res = {big.sign, res_exp[FP_EXP_W-1:0], norm_m[FP_MAN_W-1:0]};
		end
	end

	assign sum = res;

	// Saturation must cover every path into the infinity exponent
	always_comb begin
		assert final (res.exp != FP_EXP_MAX)
			else $error("fp_adder: sum exponent is 255, sum=%h", res);
	end

endmodule

//--- rtl/fp_mul.sv
`timescale 1ns/10ps
`include "xalu_cfg.svh"

module fp_mul (
	input  logic [`XALU_DATA_W-1:0] a,
	input  logic [`XALU_DATA_W-1:0] b,
	output logic [`XALU_DATA_W-1:0] product
);
	import fp_format_pkg::*;

	localparam logic signed [FP_EXP_W+1:0] EXP_SAT = {2'b00, FP_EXP_MAX};

	fp_word_t fa;
	fp_word_t fb;
	fp_word_t res;
	logic res_sign;
	logic [2*FP_MAN_W+1:0] man_prod;
	logic [FP_MAN_W-1:0] man_norm;
	logic signed [FP_EXP_W+1:0] exp_sum;

	assign fa = a;
	assign fb = b;

	assign res_sign = fa.sign ^ fb.sign;

	// Full 24x24 product of the mantissas with hidden ones
	assign man_prod = {1'b1, fa.man} * {1'b1, fb.man};

	// Product lies in [1,4), so at most one step right
	assign man_norm = man_prod[2*FP_MAN_W+1] ? man_prod[2*FP_MAN_W -: FP_MAN_W]
	                                         : man_prod[2*FP_MAN_W-1 -: FP_MAN_W];

	// Biased sum, corrected for the normalize step
	assign exp_sum = $signed({2'b00, fa.exp}) + $signed({2'b00, fb.exp})
	               - (FP_EXP_W + 2)'(FP_BIAS)
	               + $signed({9'b0, man_prod[2*FP_MAN_W+1]});

	////////////////////////////////////////
	// Result select
	////////////////////////////////////////

	always_comb begin
		if (fa.exp == '0 || fb.exp == '0) begin
			// Zero wins, even against infinity
			res = {res_sign, {(FP_EXP_W + FP_MAN_W){1'b0}}};
		end else if (fa.exp == FP_EXP_MAX || fb.exp == FP_EXP_MAX) begin
			res = {res_sign, FP_MAX_MAG};
		end else if (exp_sum >= EXP_SAT) begin
			res = {res_sign, FP_MAX_MAG};
		end else if (exp_sum <= 10'sd0) begin
			res = {res_sign, {(FP_EXP_W + FP_MAN_W){1'b0}}};
		end else begin
			// Low product bits are simply dropped
			res = {res_sign, exp_sum[FP_EXP_W-1:0], man_norm};
		end
	end

	assign product = res;

endmodule

//--- rtl/fp_convert.sv
`timescale 1ns/10ps
`include "xalu_cfg.svh"

module fp_convert (
	input  logic [`XALU_DATA_W-1:0] int_in,
	input  logic [`XALU_DATA_W-1:0] float_in,
	output logic [`XALU_DATA_W-1:0] int_to_float,
	output logic [`XALU_DATA_W-1:0] float_to_int
);
	import fp_format_pkg::*;

	// Integer saturation limits
	localparam logic [`XALU_DATA_W-1:0] INT_POS_SAT = 32'h7FFF_FFFF;
	localparam logic [`XALU_DATA_W-1:0] INT_NEG_SAT = 32'h8000_0000;

	logic [`XALU_DATA_W-1:0] int_mag;
	logic [5:0] int_lz;
	logic [`XALU_DATA_W-1:0] int_norm;
	fp_word_t itf_word;
	fp_word_t fw;
	logic signed [FP_EXP_W+1:0] unb_exp;
	logic [`XALU_DATA_W-1:0] fti_full;
	logic [`XALU_DATA_W-1:0] fti_mag;

	////////////////////////////////////////
	// Integer to float
	////////////////////////////////////////

	// Most negative input stays 80000000, read as unsigned 2^31
	assign int_mag = int_in[`XALU_DATA_W-1] ? -int_in : int_in;
	assign int_lz = fp_lead_zeros(int_mag);
	// Leading one ends up in bit 31
	assign int_norm = int_mag << int_lz;

	always_comb begin
		if (int_mag == '0) begin
			itf_word = '0;
		end else begin
			itf_word.sign = int_in[`XALU_DATA_W-1];
			itf_word.exp = FP_EXP_W'(FP_BIAS + 31 - int_lz);
			// Keep 23 bits under the leading one, rest truncated
			itf_word.man = int_norm[30 -: FP_MAN_W];
		end
	end

	assign int_to_float = itf_word;

	////////////////////////////////////////
	// Float to integer
	////////////////////////////////////////

	assign fw = float_in;
	assign unb_exp = $signed({2'b00, fw.exp}) - (FP_EXP_W + 2)'(FP_BIAS);

	// Binary point sits after bit 23 of the unshifted significand
	assign fti_full = {8'h00, 1'b1, fw.man};

	always_comb begin
		if (unb_exp >= 10'sd23) begin
			fti_mag = fti_full << (unb_exp - 10'sd23);
		end else begin
			// Fraction bits fall off, which truncates toward zero
			fti_mag = fti_full >> (10'sd23 - unb_exp);
		end
	end

	always_comb begin
		if (fw.exp == '0) begin
			float_to_int = '0;
		end else if (fw.exp == FP_EXP_MAX || unb_exp >= 10'sd31) begin
			// 2^31 and above does not fit either sign
			float_to_int = fw.sign ? INT_NEG_SAT : INT_POS_SAT;
		end else if (unb_exp < 10'sd0) begin
			float_to_int = '0;
		end else begin
			float_to_int = fw.sign ? -fti_mag : fti_mag;
		end
	end

	// Integer zero maps to positive zero, never to -0
	always_comb begin
		assert final (int_in != '0 || int_to_float == '0)
			else $error("fp_convert: zero converts to %h", int_to_float);
	end

endmodule

//--- rtl/int_mul_16by16.sv
`timescale 1ns/10ps
`include "xalu_cfg.svh"

module int_mul_16by16 (
	input  logic [`XALU_DATA_W-1:0] a,
	input  logic [`XALU_DATA_W-1:0] b,
	input  logic                    is_signed,
	output logic [`XALU_DATA_W-1:0] product
);

	// One extra bit so both modes share a signed multiply
	logic signed [`XALU_MUL_W:0] a_ext;
	logic signed [`XALU_MUL_W:0] b_ext;
	logic signed [2*`XALU_MUL_W+1:0] full_prod;

	// Top bit is the sign copy or a zero
	assign a_ext = {is_signed & a[`XALU_MUL_W-1], a[`XALU_MUL_W-1:0]};
	assign b_ext = {is_signed & b[`XALU_MUL_W-1], b[`XALU_MUL_W-1:0]};

	assign full_prod = a_ext * b_ext;

	// 32 bits hold any 16x16 product of either kind
	assign product = full_prod[`XALU_DATA_W-1:0];

endmodule

//--- rtl/extended_alu.sv
`timescale 1ns/10ps
`include "xalu_cfg.svh"

module extended_alu (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  logic [xalu_op_pkg::XALU_FUNC_W-1:0] func,
	input  logic [`XALU_DATA_W-1:0]             src1,
	input  logic [`XALU_DATA_W-1:0]             src0,
	output logic                                out_valid,
	input  logic                                out_ready,
	output logic [`XALU_DATA_W-1:0]             result,
	output logic                                zr,
	output logic                                neg
);
	import xalu_op_pkg::*;

	xalu_func_e op;
	logic [`XALU_DATA_W-1:0] fadd_b;
	logic [`XALU_DATA_W-1:0] fadd_out;
	logic [`XALU_DATA_W-1:0] fmul_out;
	logic [`XALU_DATA_W-1:0] itf_out;
	logic [`XALU_DATA_W-1:0] fti_out;
	logic [`XALU_DATA_W-1:0] imul_out;
	logic [`XALU_DATA_W-1:0] alu_word;
	logic int_word;
	logic alu_zr;
	logic alu_neg;
	logic accept;

	assign op = xalu_func_e'(func);

	////////////////////////////////////////
	// Compute units
	////////////////////////////////////////

	// SUBF is ADDF with the sign of src0 flipped
	assign fadd_b = (op == SUBF) ? {~src0[`XALU_DATA_W-1], src0[`XALU_DATA_W-2:0]} : src0;

	fp_adder u_fp_adder (
		.a   (src1),
		.b   (fadd_b),
		.sum (fadd_out)
	);

	fp_mul u_fp_mul (
		.a       (src1),
		.b       (src0),
		.product (fmul_out)
	);

	// Both directions convert src1
	fp_convert u_fp_convert (
		.int_in       (src1),
		.float_in     (src1),
		.int_to_float (itf_out),
		.float_to_int (fti_out)
	);

	int_mul_16by16 u_int_mul (
		.a         (src1),
		.b         (src0),
		.is_signed (op == MUL),
		.product   (imul_out)
	);

	////////////////////////////////////////
	// Select and flags
	////////////////////////////////////////

	always_comb begin
		case (op)
			MUL, UMUL:  alu_word = imul_out;
			ADDF, SUBF: alu_word = fadd_out;
			MULF:       alu_word = fmul_out;
			ITF:        alu_word = itf_out;
			FTI:        alu_word = fti_out;
			// FUNC_UNDEF
			default:    alu_word = `XALU_UNDEF_RESULT;
		endcase
	end

	// Integer results test all bits, float results ignore the sign
	assign int_word = (op == MUL) || (op == UMUL) || (op == FTI);
	assign alu_zr = int_word ? (alu_word == '0) : (alu_word[`XALU_DATA_W-2:0] == '0);
	// Unsigned product is never negative
	assign alu_neg = (op == UMUL) ? 1'b0 : alu_word[`XALU_DATA_W-1];

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////

	// Free slot, or the held result leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			result <= '0;
			zr <= 1'b0;
			neg <= 1'b0;
		end else begin
			if (in_ready) begin
				out_valid <= in_valid;
			end
			if (accept) begin
				result <= alu_word;
				zr <= alu_zr;
				neg <= alu_neg;
			end
		end
	end

	// Stalled result and flags hold until taken
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(result) && $stable(zr) && $stable(neg))
		else $error("extended_alu: output changed under back-pressure");

	// Empty stage always takes input
	ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> in_ready)
		else $error("extended_alu: in_ready low with empty stage");

	// Nothing offered while reset is held
	idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("extended_alu: out_valid high during reset");

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	// 100 ns period, first rising edge at 50 ns
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset held low for the first 16 rising edges, released just after
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

//--- tests/tb_extended_alu.sv
`timescale 1ns/10ps
`include "xalu_cfg.svh"

module tb_extended_alu;

	logic                                clk;
	logic                                rst_n;
	logic                                in_valid;
	logic                                in_ready;
	logic [xalu_op_pkg::XALU_FUNC_W-1:0] func;
	logic [`XALU_DATA_W-1:0]             src1;
	logic [`XALU_DATA_W-1:0]             src0;
	logic                                out_valid;
	logic                                out_ready;
	logic [`XALU_DATA_W-1:0]             result;
	logic                                zr;
	logic                                neg;

	// Vector table from the stimulus file
	logic [xalu_op_pkg::XALU_FUNC_W-1:0] vec_func [$];
	logic [`XALU_DATA_W-1:0] vec_src1 [$];
	logic [`XALU_DATA_W-1:0] vec_src0 [$];
	logic [`XALU_DATA_W-1:0] vec_result [$];
	logic vec_zr [$];
	logic vec_neg [$];

	// Indices of accepted vectors, oldest first
	int exp_q [$];

	int num_vecs = 0;
	int cur_idx = 0;
	int accept_count = 0;
	int taken_count = 0;
	int cycle_count = 0;
	int timeout_limit = 64;
	int value_errors = 0;
	int protocol_errors = 0;
	int run_errors = 0;

	// State seen at the previous falling edge
	logic stalled = 1'b0;
	logic accepted_prev = 1'b0;
	logic [`XALU_DATA_W-1:0] held_result;
	logic held_zr;
	logic held_neg;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	extended_alu u_extended_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.func      (func),
		.src1      (src1),
		.src0      (src0),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.zr        (zr),
		.neg       (neg)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic load_vectors;
		int fd;
		int fields;
		string line;
		logic [31:0] f, a, b, r, z, n;
		fd = $fopen("tests/xalu_stimulus.txt", "r");
		if (fd == 0) begin
			run_errors++;
			$display("Could not open tests/xalu_stimulus.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Lines opening with '#' carry notes only
				if (line.len() > 0 && line[0] != 8'h23) begin
					fields = $sscanf(line, "%h %h %h %h %h %h", f, a, b, r, z, n);
					if (fields == 6) begin
						vec_func.push_back(f[2:0]);
						vec_src1.push_back(a);
						vec_src0.push_back(b);
						vec_result.push_back(r);
						vec_zr.push_back(z[0]);
						vec_neg.push_back(n[0]);
						// Code 7 must expect the marker word
						if (f[2:0] == 3'd7 && r != `XALU_UNDEF_RESULT) begin
							run_errors++;
							$display("Stimulus line for code 7 does not expect the marker word");
						end
					end else if (fields > 0) begin
						run_errors++;
						$display("Malformed stimulus line: %s", line);
					end
				end
			end
			$fclose(fd);
		end
		num_vecs = vec_func.size();
	endtask

	// Called a little after each rising edge
	task automatic drive_inputs;
		// An offered vector stays until it is taken
		if (!in_valid || accept_count > cur_idx) begin
			if (accept_count >= num_vecs || $urandom % 4 == 0) begin
				in_valid = 1'b0;
			end else begin
				cur_idx = accept_count;
				in_valid = 1'b1;
				func = vec_func[cur_idx];
				src1 = vec_src1[cur_idx];
				src0 = vec_src0[cur_idx];
			end
		end
		// Random back-pressure
		out_ready = ($urandom % 4 != 0);
	endtask

	task automatic compare_result(input int idx);
		if (result !== vec_result[idx]) begin
			value_errors++;
			$display("ERROR result: got %h expected %h (vector %0d)",
				result, vec_result[idx], idx);
		end
		if (zr !== vec_zr[idx]) begin
			value_errors++;
			$display("ERROR zr: got %h expected %h (vector %0d)", zr, vec_zr[idx], idx);
		end
		if (neg !== vec_neg[idx]) begin
			value_errors++;
			$display("ERROR neg: got %h expected %h (vector %0d)", neg, vec_neg[idx], idx);
		end
	endtask

	task automatic finish_run;
		$display("Errors: value %0d, protocol %0d, run %0d",
			value_errors, protocol_errors, run_errors);
		if (value_errors + protocol_errors + run_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	////////////////////////////////////////
	// Monitor
	////////////////////////////////////////

	// Falling edge sees what the next rising edge will see
	always @(negedge clk) begin
		if (!rst_n) begin
			if (out_valid !== 1'b0) begin
				protocol_errors++;
				$display("out_valid was high while reset was held");
			end
		end else begin
			// Held values under back-pressure
			if (stalled) begin
				if (out_valid !== 1'b1) begin
					protocol_errors++;
					$display("out_valid dropped while the result was not taken");
				end
				if (result !== held_result) begin
					value_errors++;
					$display("ERROR result: changed under stall, got %h expected %h",
						result, held_result);
				end
				if (zr !== held_zr) begin
					value_errors++;
					$display("ERROR zr: changed under stall, got %h expected %h",
						zr, held_zr);
				end
				if (neg !== held_neg) begin
					value_errors++;
					$display("ERROR neg: changed under stall, got %h expected %h",
						neg, held_neg);
				end
			end
			// One cycle latency
			if (accepted_prev && out_valid !== 1'b1) begin
				protocol_errors++;
				$display("Result did not appear the cycle after acceptance");
			end
			if (accept_count == 0 && out_valid !== 1'b0) begin
				protocol_errors++;
				$display("out_valid was high before any operation was accepted");
			end
			// Ready while empty or while the held result leaves
			if (in_ready !== (!out_valid || out_ready)) begin
				protocol_errors++;
				$display("ERROR in_ready: got %h expected %h",
					in_ready, (!out_valid || out_ready));
			end
			// Result taken at the coming edge
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					run_errors++;
					$display("A result was offered with no operation outstanding");
				end else begin
					compare_result(exp_q.pop_front());
					taken_count++;
				end
			end
			stalled = out_valid && !out_ready;
			held_result = result;
			held_zr = zr;
			held_neg = neg;
			// Operation accepted at the coming edge
			accepted_prev = in_valid && in_ready;
			if (accepted_prev) begin
				exp_q.push_back(cur_idx);
				accept_count++;
			end
		end
	end

	////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////

	initial begin
		void'($urandom(61));
		in_valid = 1'b0;
		func = '0;
		src1 = '0;
		src0 = '0;
		out_ready = 1'b0;
		load_vectors();
		timeout_limit = 4 * num_vecs + 64;
		if (num_vecs == 0) begin
			run_errors++;
			$display("No vectors were loaded from the stimulus file");
		end
		if (run_errors == 0) begin
			wait (rst_n === 1'b1);
			while (taken_count < num_vecs) begin
				@(posedge clk);
				#1;
				drive_inputs();
			end
			@(posedge clk);
		end
		finish_run();
	end

	// Cycles counted from reset release
	initial begin
		wait (rst_n === 1'b1);
		while (cycle_count <= timeout_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		run_errors++;
		$display("Timeout after %0d cycles, %0d of %0d results taken",
			cycle_count, taken_count, num_vecs);
		finish_run();
	end

endmodule

//--- tests/xalu_stimulus.txt
# func src1 src0 result zr neg, all hex
# func 0 MUL, 1 UMUL, 2 ADDF, 3 SUBF, 4 MULF, 5 ITF, 6 FTI, 7 undefined
0 0000FFFF 0000FFFF 00000001 0 0
1 0000FFFF 0000FFFF FFFE0001 0 0
0 12340003 ABCD0004 0000000C 0 0
0 0000FFFE 00000003 FFFFFFFA 0 1
1 0000FFFE 00000003 0002FFFA 0 0
0 00008000 00008000 40000000 0 0
0 00007FFF 00008000 C0008000 0 1
1 FFFF0000 00001234 00000000 1 0
2 3F800000 3F000000 3FC00000 0 0
3 3F800000 3F800000 00000000 1 0
3 3F800000 40000000 BF800000 0 1
2 3F800001 34000000 3F800002 0 0
2 3F800000 33800000 3F800000 0 0
2 7F7FFFFF 7F7FFFFF 7F7FFFFF 0 0
3 FF7FFFFF 7F7FFFFF FF7FFFFF 0 1
2 3F800000 FF800000 FF7FFFFF 0 1
2 00012345 40000000 40000000 0 0
2 80000000 80400000 80000000 1 1
3 80800001 80800000 80000000 1 1
4 40000000 40400000 40C00000 0 0
4 3FFFFFFF 3FFFFFFF 407FFFFE 0 0
4 C0000000 3F800000 C0000000 0 1
4 00000000 C0400000 80000000 1 1
4 7F000000 C0000000 FF7FFFFF 0 1
4 7F800000 3F800000 7F7FFFFF 0 0
5 00000000 00000000 00000000 1 0
5 FFFFFFFF 00000000 BF800000 0 1
5 7FFFFFFF 00000000 4EFFFFFF 0 0
5 80000000 00000000 CF000000 0 1
6 3FC00000 00000000 00000001 0 0
6 C0200000 00000000 FFFFFFFE 0 1
6 3F000000 00000000 00000000 1 0
6 4EFFFFFF 00000000 7FFFFF80 0 0
6 4F000000 00000000 7FFFFFFF 0 0
6 CF000000 00000000 80000000 0 1
7 12345678 9ABCDEF0 DEADDEAD 0 1

//--- files.f
+incdir+rtl
rtl/xalu_op_pkg.sv
rtl/fp_format_pkg.sv
rtl/fp_adder.sv
rtl/fp_mul.sv
rtl/fp_convert.sv
rtl/int_mul_16by16.sv
rtl/extended_alu.sv
tests/tb_clock_gen.sv
tests/tb_extended_alu.sv

//--- Makefile
TOP := tb_extended_alu
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir $(OBJ) -o sim_$(TOP)
	@out="$$(./$(OBJ)/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ)
